// ==== Bender.yml ====
package:
  name: blitter

sources:
  - verilog/blit_pkg.sv
  - verilog/blit_regs.sv
  - verilog/blit_addr_gen.sv
  - verilog/blit_bus_master.sv
  - verilog/blit_datapath.sv
  - verilog/blit_ctrl.sv
  - verilog/blitter.sv
  - target: test
    files:
      - verif/blitter_sva.sv
      - verif/blitter_tb.sv

// ==== tb.f ====
verilog/blit_pkg.sv
verilog/blit_regs.sv
verilog/blit_addr_gen.sv
verilog/blit_bus_master.sv
verilog/blit_datapath.sv
verilog/blit_ctrl.sv
verilog/blitter.sv
verif/blitter_sva.sv
verif/blitter_tb.sv

// ==== verif/blitter_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module blitter_sva (
   input logic            clk,
   input logic            reset,
   input logic            mem_req,
   input logic            mem_we,
   input blit_pkg::addr_t mem_addr,
   input logic            mem_ack,
   input logic            busy
);
   int fails = 0;

   // --------------------------------------------------
   // four phase handshake
   // --------------------------------------------------
   // req stays up until the memory answers
   req_holds: assert property (@(posedge clk) disable iff (reset)
      mem_req && !mem_ack |=> mem_req)
      else begin $error("mem_req fell before mem_ack"); fails++; end

   // address and direction frozen for the whole request
   addr_stable: assert property (@(posedge clk) disable iff (reset)
      mem_req && $past(mem_req) |-> $stable(mem_addr) && $stable(mem_we))
      else begin $error("mem_addr or mem_we changed during mem_req"); fails++; end

   ack_needs_req: assert property (@(posedge clk) disable iff (reset)
      $rose(mem_ack) |-> mem_req)
      else begin $error("mem_ack rose without mem_req"); fails++; end

   // bus is quiet outside a job
   req_only_busy: assert property (@(posedge clk) disable iff (reset)
      !busy |-> !mem_req)
      else begin $error("mem_req high while busy is low"); fails++; end

endmodule

bind blitter blitter_sva sva_i (
   .clk(clk), .reset(reset), .mem_req(mem_req), .mem_we(mem_we),
   .mem_addr(mem_addr), .mem_ack(mem_ack), .busy(busy)
);

`default_nettype wire

// ==== verif/blitter_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module blitter_tb;
   import blit_pkg::*;

   localparam int num_jobs  = 40;
   localparam int mem_words = 4096;
   // 4 rows of 6 words at most
   localparam int max_words = 24;
   // words between rows of a rectangle
   localparam int pitch     = 16;
   // three accesses per word of about 12 cycles each, plus register setup per job
   localparam int timeout_cycles = num_jobs * (max_words * 3 * 12 + 100) + 500;

   logic    clk;
   logic    reset;
   reg_wr_t wr;
   logic    mem_req;
   logic    mem_we;
   addr_t   mem_addr;
   word_t   mem_wdata;
   logic    mem_ack;
   word_t   mem_rdata;
   logic    busy;

   integer seed = 93323;
   int mismatches = 0;
   int failures = 0;
   int cycles = 0;

   // memory behind the bus, and the expected image of it
   word_t mem [mem_words];
   word_t shadow [mem_words];
   bit    in_dst [mem_words];
   bit    job_src;
   int    rd_count;
   int    wr_count;
   int    exp_reads;
   int    exp_writes;
   // model of the source buffer and destination latch, kept across jobs
   logic [31:0] model_buf = '0;
   word_t       model_d = '0;

   blitter dut_i (
      .clk(clk), .reset(reset), .wr(wr),
      .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
      .mem_ack(mem_ack), .mem_rdata(mem_rdata), .busy(busy)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;

   function automatic int rand_range(input int lo, input int hi);
      int r;
      r = $random(seed);
      return lo + int'($unsigned(r) % (hi - lo + 1));
   endfunction

   // op bit index is {~s, ~d}, so op 1 is s and d, op 8 is neither
   function automatic word_t apply_op(input op_t op, input word_t s, input word_t d);
      word_t r;
      for (int b = 0; b < 16; b++) begin
         r[b] = op[{~s[b], ~d[b]}];
      end
      return r;
   endfunction

   // --------------------------------------------------
   // memory model, four phase slave with random delays
   // --------------------------------------------------
   initial begin : memory_model
      int a;
      forever begin
         @(negedge clk);
         if (mem_req && !reset) begin
            repeat (rand_range(0, 3)) @(negedge clk);
            a = int'(mem_addr);
            if (a >= mem_words) begin
               failures++;
               $display("access to address %0d outside the memory at %0t", a, $time);
            end else if (mem_we) begin
               wr_count++;
               if (!in_dst[a]) begin
                  failures++;
                  $display("write to %0d outside the destination region at %0t", a, $time);
               end
               mem[a] = mem_wdata;
            end else begin
               rd_count++;
               // ops without a source only touch the destination
               if (!job_src && !in_dst[a]) begin
                  failures++;
                  $display("read of %0d outside the destination region at %0t", a, $time);
               end
               mem_rdata = mem[a];
            end
            mem_ack = 1'b1;
            do @(negedge clk); while (mem_req);
            repeat (rand_range(0, 3)) @(negedge clk);
            mem_ack = 1'b0;
         end
      end
   end

   // job watchdog
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles == timeout_cycles) begin
         $display("timeout, jobs did not finish within %0d cycles", timeout_cycles);
         $display("mismatches %0d, other errors %0d", mismatches, failures + 1);
         $display("sim failed");
         $finish;
      end
   end

   // one cycle register strobe, driven on the falling edge
   task automatic write_reg(input reg_addr_t a, input word_t data, input logic uds,
                            input logic lds);
      @(negedge clk);
      wr.valid = 1'b1;
      wr.addr  = a;
      wr.data  = data;
      wr.uds   = uds;
      wr.lds   = lds;
      @(negedge clk);
      wr.valid = 1'b0;
   endtask

   // --------------------------------------------------
   // reference model, word walk on the shadow memory
   // --------------------------------------------------
   task automatic run_model(input op_t op, input skew_t skew, input word_t em1,
                            input word_t em2, input word_t em3, input int w, input int h,
                            input int sa, input int sxi, input int syi,
                            input int da, input int dxi, input int dyi);
      word_t mask;
      word_t s;
      bit    use_dst;
      job_src = !(op == 4'd0 || op == 4'd5 || op == 4'd10 || op == 4'd15);
      use_dst = !(op == 4'd0 || op == 4'd3 || op == 4'd12 || op == 4'd15);
      for (int y = 0; y < h; y++) begin
         for (int x = 0; x < w; x++) begin
            // first mask wins on a one word row
            mask = (x == 0) ? em1 : ((x == w - 1) ? em3 : em2);
            if (job_src) begin
               exp_reads++;
               if (sxi >= 0) model_buf = {model_buf[15:0], shadow[sa]};
               else model_buf = {shadow[sa], model_buf[31:16]};
               sa += (x == w - 1) ? syi : sxi;
            end
            if (use_dst || mask != 16'hffff) begin
               exp_reads++;
               model_d = shadow[da];
            end
            s = word_t'(model_buf >> skew);
            shadow[da] = (apply_op(op, s, model_d) & mask) | (model_d & ~mask);
            in_dst[da] = 1'b1;
            exp_writes++;
            da += (x == w - 1) ? dyi : dxi;
         end
      end
   endtask

   task automatic check_results();
      if (rd_count != exp_reads) begin
         mismatches++;
         $display("mismatch at %0t: read_count expected %0d got %0d",
                  $time, exp_reads, rd_count);
      end
      if (wr_count != exp_writes) begin
         mismatches++;
         $display("mismatch at %0t: write_count expected %0d got %0d",
                  $time, exp_writes, wr_count);
      end
      for (int i = 0; i < mem_words; i++) begin
         if (mem[i] !== shadow[i]) begin
            mismatches++;
            $display("mismatch at %0t: mem[%0d] expected %h got %h",
                     $time, i, shadow[i], mem[i]);
         end
         // resync so one bad word is not counted again
         shadow[i] = mem[i];
      end
   endtask

   // --------------------------------------------------
   // one job: program, model, start, wait, compare
   // --------------------------------------------------
   task automatic run_job(input op_t op, input skew_t skew, input word_t em1,
                          input word_t em2, input word_t em3, input int w, input int h,
                          input int sx, input int dx, input bit retrigger);
      int sa;
      int da;
      int syi;
      int dyi;
      // walking left starts at the right end of the row
      sa  = 8 + rand_range(0, 900) + ((sx < 0) ? w - 1 : 0);
      da  = 2056 + rand_range(0, 900) + ((dx < 0) ? w - 1 : 0);
      syi = pitch - sx * (w - 1);
      dyi = pitch - dx * (w - 1);
      // increments and addresses are written as byte values
      write_reg(reg_src_x_inc, word_t'(sx * 2), 1'b1, 1'b1);
      write_reg(reg_src_y_inc, word_t'(syi * 2), 1'b1, 1'b1);
      write_reg(reg_dst_x_inc, word_t'(dx * 2), 1'b1, 1'b1);
      write_reg(reg_dst_y_inc, word_t'(dyi * 2), 1'b1, 1'b1);
      write_reg(reg_src_addr_hi, 16'h0000, 1'b1, 1'b1);
      write_reg(reg_src_addr_lo, word_t'(sa * 2), 1'b1, 1'b1);
      write_reg(reg_dst_addr_hi, 16'h0000, 1'b1, 1'b1);
      write_reg(reg_dst_addr_lo, word_t'(da * 2), 1'b1, 1'b1);
      write_reg(reg_endmask1, em1, 1'b1, 1'b1);
      write_reg(reg_endmask2, em2, 1'b1, 1'b1);
      write_reg(reg_endmask3, em3, 1'b1, 1'b1);
      write_reg(reg_op, word_t'(op), 1'b1, 1'b1);
      write_reg(reg_x_count, word_t'(w), 1'b1, 1'b1);
      write_reg(reg_y_count, word_t'(h), 1'b1, 1'b1);
      for (int i = 0; i < mem_words; i++) in_dst[i] = 1'b0;
      rd_count   = 0;
      wr_count   = 0;
      exp_reads  = 0;
      exp_writes = 0;
      run_model(op, skew, em1, em2, em3, w, h, sa, sx, syi, da, dx, dyi);
      write_reg(reg_ctrl, {12'h800, skew}, 1'b1, 1'b1);
      if (busy !== 1'b1) begin
         mismatches++;
         $display("mismatch at %0t: busy expected 1 got %b", $time, busy);
      end
      // start again while busy, upper byte only so skew stays
      if (retrigger) begin
         // let the second access begin so the engine is past its first state
         while (busy && !mem_req) @(negedge clk);
         while (busy && mem_req) @(negedge clk);
         while (busy && !mem_req) @(negedge clk);
         if (busy) begin
            write_reg(reg_ctrl, 16'h8000, 1'b1, 1'b0);
         end
      end
      while (busy) @(negedge clk);
      check_results();
   endtask

   // start with no rows, nothing may move
   task automatic zero_rows_job();
      bit moved;
      moved    = 1'b0;
      rd_count = 0;
      wr_count = 0;
      write_reg(reg_x_count, 16'd1, 1'b1, 1'b1);
      write_reg(reg_y_count, 16'd0, 1'b1, 1'b1);
      write_reg(reg_ctrl, 16'h8000, 1'b1, 1'b1);
      repeat (12) begin
         if (busy || mem_req) moved = 1'b1;
         @(negedge clk);
      end
      if (moved || rd_count != 0 || wr_count != 0) begin
         failures++;
         $display("busy or mem_req rose after a start with a y count of 0 at %0t", $time);
      end
   endtask

   // --------------------------------------------------
   // stimulus
   // --------------------------------------------------
   initial begin : main
      int    w;
      int    h;
      int    total;
      op_t   op;
      word_t em1;
      word_t em2;
      word_t em3;
      reset     = 1'b1;
      wr        = '0;
      mem_ack   = 1'b0;
      mem_rdata = '0;
      for (int i = 0; i < mem_words; i++) begin
         mem[i]    = word_t'($random(seed));
         shadow[i] = mem[i];
      end
      repeat (5) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      for (int j = 0; j < num_jobs; j++) begin
         if (j < 6) begin
            // plain copy, first job fills both halves of the source buffer
            w = rand_range((j == 0) ? 2 : 1, 6);
            h = rand_range(1, 4);
            run_job(4'd3, 4'd0, 16'hffff, 16'hffff, 16'hffff, w, h, 1, 1, 1'b0);
         end else if (j < 8) begin
            zero_rows_job();
         end else begin
            op  = op_t'(rand_range(0, 15));
            em1 = word_t'($random(seed));
            em2 = word_t'($random(seed));
            em3 = word_t'($random(seed));
            // source free ops
            if (j % 4 == 0) op = op_t'(5 * rand_range(0, 3));
            // constant ops with full masks need no reads at all
            if (j % 8 == 0) begin
               op  = op_t'(15 * rand_range(0, 1));
               em1 = 16'hffff;
               em2 = 16'hffff;
               em3 = 16'hffff;
            end
            run_job(op, skew_t'(rand_range(0, 15)), em1, em2, em3,
                    rand_range(1, 6), rand_range(1, 4),
                    rand_range(0, 1) ? 1 : -1, rand_range(0, 1) ? 1 : -1, j % 3 == 0);
         end
      end
      repeat (4) @(negedge clk);
      total = mismatches + failures + dut_i.sva_i.fails;
      $display("mismatches %0d, other errors %0d, assertion failures %0d",
               mismatches, failures, dut_i.sva_i.fails);
      if (total == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/blit_addr_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module blit_addr_gen (
   input  logic              clk,
   input  blit_pkg::reg_wr_t wr,
   input  blit_pkg::step_t   step,
   output blit_pkg::addr_t   src_addr,
   output blit_pkg::addr_t   dst_addr
);
   import blit_pkg::*;

   inc_t src_x_inc;
   inc_t src_y_inc;
   inc_t dst_x_inc;
   inc_t dst_y_inc;

   // sign extend a word step to the address width
   function automatic addr_t sext(input inc_t inc);
      return {{(addr_w-inc_w){inc[inc_w-1]}}, inc};
   endfunction

   always_ff @(posedge clk) begin
      if (wr.valid) begin
         case (wr.addr)
            reg_src_x_inc:   src_x_inc <= wr.data[word_w-1:1];
            reg_src_y_inc:   src_y_inc <= wr.data[word_w-1:1];
            reg_dst_x_inc:   dst_x_inc <= wr.data[word_w-1:1];
            reg_dst_y_inc:   dst_y_inc <= wr.data[word_w-1:1];
            // high half holds byte address bits 23..16
            reg_src_addr_hi: src_addr[addr_w-1:inc_w] <= wr.data[7:0];
            reg_src_addr_lo: src_addr[inc_w-1:0]      <= wr.data[word_w-1:1];
            reg_dst_addr_hi: dst_addr[addr_w-1:inc_w] <= wr.data[7:0];
            reg_dst_addr_lo: dst_addr[inc_w-1:0]      <= wr.data[word_w-1:1];
            default: ;
         endcase
      end
      // x step inside a row, y step at its last word
      if (step.src_x) begin
         src_addr <= src_addr + sext(src_x_inc);
      end
      if (step.src_y) begin
         src_addr <= src_addr + sext(src_y_inc);
      end
      if (step.dst_x) begin
         dst_addr <= dst_addr + sext(dst_x_inc);
      end
      if (step.dst_y) begin
         dst_addr <= dst_addr + sext(dst_y_inc);
      end
   end

endmodule

`default_nettype wire

// ==== verilog/blit_bus_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module blit_bus_master (
   input  logic               clk,
   input  logic               reset,
   input  blit_pkg::mem_cmd_t cmd,
   input  logic               mem_ack,
   input  blit_pkg::word_t    mem_rdata,
   output logic               cmd_done,
   output blit_pkg::word_t    rdata,
   output logic               mem_req,
   output logic               mem_we,
   output blit_pkg::addr_t    mem_addr,
   output blit_pkg::word_t    mem_wdata
);
   import blit_pkg::*;

   typedef enum logic [1:0] {
      ph_idle,
      ph_request,
      ph_release,
      ph_done
   } phase_t;

   phase_t phase;

   // --------------------------------------------------
   // four phase handshake
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         phase    <= ph_idle;
         mem_req  <= 1'b0;
         mem_we   <= 1'b0;
         cmd_done <= 1'b0;
      end else begin
         cmd_done <= 1'b0;
         case (phase)
            ph_idle: begin
               // req goes up together with the registered command
               if (cmd.valid) begin
                  mem_req <= 1'b1;
                  mem_we  <= cmd.we;
                  phase   <= ph_request;
               end
            end
            ph_request: begin
               if (mem_ack) begin
                  mem_req <= 1'b0;
                  mem_we  <= 1'b0;
                  phase   <= ph_release;
               end
            end
            ph_release: begin
               // wait for the memory to drop ack
               if (!mem_ack) begin
                  cmd_done <= 1'b1;
                  phase    <= ph_done;
               end
            end
            default: begin
               phase <= ph_idle;
            end
         endcase
      end
   end

   // address, write data and read data
   always_ff @(posedge clk) begin
      if (phase == ph_idle && cmd.valid) begin
         mem_addr  <= cmd.addr;
         mem_wdata <= cmd.wdata;
      end
      if (phase == ph_request && mem_ack) begin
         rdata <= mem_rdata;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/blit_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module blit_ctrl (
   input  logic               clk,
   input  logic               reset,
   input  blit_pkg::reg_wr_t  wr,
   input  blit_pkg::op_t      op,
   input  blit_pkg::word_t    endmask1,
   input  blit_pkg::word_t    endmask2,
   input  blit_pkg::word_t    endmask3,
   input  blit_pkg::addr_t    src_addr,
   input  blit_pkg::addr_t    dst_addr,
   input  logic               cmd_done,
   input  blit_pkg::word_t    wdata_in,
   output blit_pkg::mem_cmd_t cmd,
   output blit_pkg::step_t    step,
   output logic               src_load,
   output logic               dst_load,
   output logic               busy,
   output blit_pkg::word_t    cur_mask
);
   import blit_pkg::*;

   blit_state_t state;
   blit_state_t first_state;
   word_t x_count;
   word_t x_count_latch;
   word_t y_count;
   // one idle cycle between accesses
   logic gap;
   logic start;
   logic need_src;
   logic op_needs_dst;
   logic need_dst;
   logic first_word;
   logic last_word;
   logic wr_done;

   // --------------------------------------------------
   // op and mask decode
   // --------------------------------------------------
   // ops 0, 5, 10 and 15 never look at the source
   assign need_src = !(op == 4'd0 || op == 4'd5 || op == 4'd10 || op == 4'd15);
   // ops 0, 3, 12 and 15 never look at the destination
   assign op_needs_dst = !(op == 4'd0 || op == 4'd3 || op == 4'd12 || op == 4'd15);

   assign first_word = (x_count == x_count_latch);
   assign last_word  = (x_count == word_t'(1));

   // first mask wins on a one word row
   assign cur_mask = first_word ? endmask1 : (last_word ? endmask3 : endmask2);
   assign need_dst = op_needs_dst || (cur_mask != full_mask);

   // every word opens with a source read if the op wants one
   assign first_state = need_src ? st_src_read : st_dst_read;

   // start only from idle and with rows to do
   assign start = wr.valid && (wr.addr == reg_ctrl) && wr.uds && wr.data[word_w-1]
                  && !busy && (y_count != '0);

   // --------------------------------------------------
   // memory command and strobes
   // --------------------------------------------------
   assign cmd.valid = (state != st_idle) && !gap;
   assign cmd.we    = (state == st_dst_write);
   assign cmd.addr  = (state == st_src_read) ? src_addr : dst_addr;
   assign cmd.wdata = wdata_in;

   assign src_load = cmd_done && (state == st_src_read);
   assign dst_load = cmd_done && (state == st_dst_read);
   assign wr_done  = cmd_done && (state == st_dst_write);

   assign step.src_x = src_load && !last_word;
   assign step.src_y = src_load && last_word;
   assign step.dst_x = wr_done && !last_word;
   assign step.dst_y = wr_done && last_word;

   // --------------------------------------------------
   // state machine and counters
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         state         <= st_idle;
         busy          <= 1'b0;
         gap           <= 1'b0;
         x_count       <= '0;
         x_count_latch <= '0;
         y_count       <= '0;
      end else begin
         gap <= 1'b0;
         // x count is latched for the reload at each row end
         if (wr.valid && wr.addr == reg_x_count) begin
            x_count       <= wr.data;
            x_count_latch <= wr.data;
         end
         if (wr.valid && wr.addr == reg_y_count) begin
            y_count <= wr.data;
         end
         if (start) begin
            busy  <= 1'b1;
            gap   <= 1'b1;
            state <= first_state;
         end
         // counts and mask are settled in the gap, so skip a needless read here
         if (gap && state == st_dst_read && !need_dst) begin
            state <= st_dst_write;
         end
         if (cmd_done) begin
            gap <= 1'b1;
            case (state)
               st_src_read:  state <= st_dst_read;
               st_dst_read:  state <= st_dst_write;
               st_dst_write: begin
                  if (last_word) begin
                     x_count <= x_count_latch;
                     y_count <= y_count - 1'b1;
                     // last row done
                     if (y_count == word_t'(1)) begin
                        state <= st_idle;
                        busy  <= 1'b0;
                     end else begin
                        state <= first_state;
                     end
                  end else begin
                     x_count <= x_count - 1'b1;
                     state   <= first_state;
                  end
               end
               default: state <= st_idle;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// ==== verilog/blit_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module blit_datapath (
   input  logic            clk,
   input  logic            src_load,
   input  logic            dst_load,
   input  blit_pkg::word_t rdata,
   input  blit_pkg::inc_t  src_x_inc,
   input  blit_pkg::skew_t skew,
   input  blit_pkg::op_t   op,
   input  blit_pkg::word_t cur_mask,
   output blit_pkg::word_t result
);
   import blit_pkg::*;

   logic [2*word_w-1:0] src_buf;
   word_t d;
   word_t s;
   word_t op_out;

   // --------------------------------------------------
   // source buffer and destination latch
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (src_load) begin
         // walking right fills from below, walking left from above
         if (!src_x_inc[inc_w-1]) begin
            src_buf <= {src_buf[word_w-1:0], rdata};
         end else begin
            src_buf <= {rdata, src_buf[2*word_w-1:word_w]};
         end
      end
      if (dst_load) begin
         d <= rdata;
      end
   end

   // skewed source word
   assign s = src_buf[skew +: word_w];

   // --------------------------------------------------
   // logic op
   // --------------------------------------------------
   always_comb begin
      case (op)
         4'd0:    op_out = '0;
         4'd1:    op_out =  s &  d;
         4'd2:    op_out =  s & ~d;
         4'd3:    op_out =  s;
         4'd4:    op_out = ~s &  d;
         4'd5:    op_out =  d;
         4'd6:    op_out =  s ^  d;
         4'd7:    op_out =  s |  d;
         4'd8:    op_out = ~s & ~d;
         4'd9:    op_out = ~s ^  d;
         4'd10:   op_out = ~d;
         4'd11:   op_out =  s | ~d;
         4'd12:   op_out = ~s;
         4'd13:   op_out = ~s |  d;
         4'd14:   op_out = ~s | ~d;
         default: op_out = '1;
      endcase
   end

   // masked bits keep the destination
   assign result = (op_out & cur_mask) | (d & ~cur_mask);

endmodule

`default_nettype wire

// ==== verilog/blit_pkg.sv ====
`default_nettype none

package blit_pkg;

   // --------------------------------------------------
   // widths
   // --------------------------------------------------
   localparam int word_w     = 16;
   localparam int addr_w     = 23;
   localparam int inc_w      = 15;
   localparam int reg_addr_w = 5;
   localparam int op_w       = 4;
   localparam int skew_w     = 4;

   typedef logic [word_w-1:0]            word_t;
   // word address, byte address bits 23..1
   typedef logic [addr_w-1:0]            addr_t;
   // signed step in words, byte increment bits 15..1
   typedef logic signed [inc_w-1:0]      inc_t;
   typedef logic [reg_addr_w-1:0]        reg_addr_t;
   typedef logic [op_w-1:0]              op_t;
   typedef logic [skew_w-1:0]            skew_t;

   // all ones mask, no destination read needed for it
   localparam word_t full_mask = '1;

   // one cpu register write, uds and lds are active high byte strobes
   typedef struct packed {
      logic      valid;
      reg_addr_t addr;
      word_t     data;
      logic      uds;
      logic      lds;
   } reg_wr_t;

   // one memory access request
   typedef struct packed {
      logic  valid;
      logic  we;
      addr_t addr;
      word_t wdata;
   } mem_cmd_t;

   // address step strobes
   typedef struct packed {
      logic src_x;
      logic src_y;
      logic dst_x;
      logic dst_y;
   } step_t;

   typedef enum logic [1:0] {
      st_idle,
      st_src_read,
      st_dst_read,
      st_dst_write
   } blit_state_t;

   // --------------------------------------------------
   // register map
   // --------------------------------------------------
   localparam reg_addr_t reg_src_x_inc   = 5'h10;
   localparam reg_addr_t reg_src_y_inc   = 5'h11;
   localparam reg_addr_t reg_src_addr_hi = 5'h12;
   localparam reg_addr_t reg_src_addr_lo = 5'h13;
   localparam reg_addr_t reg_endmask1    = 5'h14;
   localparam reg_addr_t reg_endmask2    = 5'h15;
   localparam reg_addr_t reg_endmask3    = 5'h16;
   localparam reg_addr_t reg_dst_x_inc   = 5'h17;
   localparam reg_addr_t reg_dst_y_inc   = 5'h18;
   localparam reg_addr_t reg_dst_addr_hi = 5'h19;
   localparam reg_addr_t reg_dst_addr_lo = 5'h1a;
   localparam reg_addr_t reg_x_count     = 5'h1b;
   localparam reg_addr_t reg_y_count     = 5'h1c;
   // op in bits 3..0 under lds
   localparam reg_addr_t reg_op          = 5'h1d;
   // busy in bit 15 under uds, skew in bits 3..0 under lds
   localparam reg_addr_t reg_ctrl        = 5'h1e;

endpackage

`default_nettype wire

// ==== verilog/blit_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module blit_regs (
   input  logic              clk,
   input  logic              reset,
   input  blit_pkg::reg_wr_t wr,
   output blit_pkg::inc_t    src_x_inc,
   output blit_pkg::word_t   endmask1,
   output blit_pkg::word_t   endmask2,
   output blit_pkg::word_t   endmask3,
   output blit_pkg::op_t     op,
   output blit_pkg::skew_t   skew
);
   import blit_pkg::*;

   logic op_wr;
   logic skew_wr;

   // byte wide fields only take the low byte lane
   assign op_wr   = wr.valid && (wr.addr == reg_op) && wr.lds;
   assign skew_wr = wr.valid && (wr.addr == reg_ctrl) && wr.lds;

   // --------------------------------------------------
   // op and skew
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         op   <= '0;
         skew <= '0;
      end else begin
         if (op_wr) begin
            op <= wr.data[op_w-1:0];
         end
         if (skew_wr) begin
            skew <= wr.data[skew_w-1:0];
         end
      end
   end

   // --------------------------------------------------
   // word wide registers
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (wr.valid) begin
         case (wr.addr)
            // bit 0 of a byte increment is dropped
            reg_src_x_inc: src_x_inc <= wr.data[word_w-1:1];
            reg_endmask1:  endmask1  <= wr.data;
            reg_endmask2:  endmask2  <= wr.data;
            reg_endmask3:  endmask3  <= wr.data;
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== verilog/blitter.sv ====
`timescale 1ns/1ps
`default_nettype none

module blitter (
   input  logic              clk,
   input  logic              reset,
   input  blit_pkg::reg_wr_t wr,
   output logic              mem_req,
   output logic              mem_we,
   output blit_pkg::addr_t   mem_addr,
   output blit_pkg::word_t   mem_wdata,
   input  logic              mem_ack,
   input  blit_pkg::word_t   mem_rdata,
   output logic              busy
);
   import blit_pkg::*;

   inc_t     src_x_inc;
   word_t    endmask1;
   word_t    endmask2;
   word_t    endmask3;
   op_t      op;
   skew_t    skew;
   addr_t    src_addr;
   addr_t    dst_addr;
   mem_cmd_t cmd;
   step_t    step;
   logic     cmd_done;
   word_t    rdata;
   logic     src_load;
   logic     dst_load;
   word_t    cur_mask;
   word_t    result;

   // configuration fixed during a job
   blit_regs regs_i (
      .clk(clk), .reset(reset), .wr(wr),
      .src_x_inc(src_x_inc), .endmask1(endmask1), .endmask2(endmask2),
      .endmask3(endmask3), .op(op), .skew(skew)
   );

   blit_addr_gen addr_gen_i (
      .clk(clk), .wr(wr), .step(step),
      .src_addr(src_addr), .dst_addr(dst_addr)
   );

   blit_ctrl ctrl_i (
      .clk(clk), .reset(reset), .wr(wr), .op(op),
      .endmask1(endmask1), .endmask2(endmask2), .endmask3(endmask3),
      .src_addr(src_addr), .dst_addr(dst_addr), .cmd_done(cmd_done),
      .wdata_in(result), .cmd(cmd), .step(step),
      .src_load(src_load), .dst_load(dst_load), .busy(busy), .cur_mask(cur_mask)
   );

   blit_bus_master bus_master_i (
      .clk(clk), .reset(reset), .cmd(cmd), .mem_ack(mem_ack), .mem_rdata(mem_rdata),
      .cmd_done(cmd_done), .rdata(rdata), .mem_req(mem_req), .mem_we(mem_we),
      .mem_addr(mem_addr), .mem_wdata(mem_wdata)
   );

   // shifter, logic op and mask merge
   blit_datapath datapath_i (
      .clk(clk), .src_load(src_load), .dst_load(dst_load), .rdata(rdata),
      .src_x_inc(src_x_inc), .skew(skew), .op(op), .cur_mask(cur_mask),
      .result(result)
   );

endmodule

`default_nettype wire
